// File: list.f
+incdir+src
src/lu_pkg.sv
src/matrix_loader.sv
src/diag_pe.sv
src/offdiag_pe.sv
src/lu_pe_array.sv
src/result_collector.sv
src/lu_decomp_top.sv
verification/lu_props.sv
verification/lu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the LU testbench with Verilator, output goes to sim.log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lu_tb -f list.f -o lu_sim \
    > sim.log 2>&1 &&
./obj_dir/lu_sim >> sim.log 2>&1 ||
echo "test failed" >> sim.log
grep -q "test failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

// File: src/diag_pe.sv
module diag_pe #(
    // Step on which the pivot reaches this cell.
    parameter int FIRST_STEP = 1
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          step_en,
    input  logic          start,
    input  lu_pkg::word_t a_in,
    output lu_pkg::word_t u_out
);
    import lu_pkg::*;

    logic [3:0] slot_q;
    logic [3:0] slot;
    logic       active;
    word_t      u_q;

    // Step index within the current matrix.
    assign slot   = start ? 4'd0 : slot_q;
    assign active = int'(slot) >= FIRST_STEP;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q <= '0;
        end else if (step_en) begin
            slot_q <= slot + 4'd1;
        end
    end

    // First value taken is the pivot, the rest of the U row follows.
    always_ff @(posedge clk) begin
        if (step_en) begin
            if (active) u_q <= a_in;
            else u_q <= '0;
        end
    end

    assign u_out = u_q;

endmodule

// File: src/lu_cfg.svh
`ifndef LU_CFG_SVH
`define LU_CFG_SVH

// Matrix dimension. The skew and capture schedule are written for 3.
`define LU_N 3

// Signed Q8.8 words.
`define LU_DWIDTH 16
`define LU_FRAC 8

// Steps in one wavefront pass.
`define LU_STEPS 9

`endif

// File: src/lu_decomp_top.sv
`include "lu_cfg.svh"

module lu_decomp_top (
    input  logic          clk,
    input  logic          rst_n,
    input  lu_pkg::word_t mat_in [`LU_N][`LU_N],
    input  logic          in_valid,
    output logic          in_ready,
    output lu_pkg::word_t l_out [`LU_N][`LU_N],
    output lu_pkg::word_t u_out [`LU_N][`LU_N],
    output logic          singular,
    output logic          out_valid,
    input  logic          out_ready
);
    import lu_pkg::*;

    logic       step_en;
    logic       start;
    logic       done;
    logic [3:0] step_cnt;
    logic [2:0] pe_zero_div;
    word_t      a_row0;
    word_t      a_row1;
    word_t      a_row2;
    word_t      u_bot [`LU_N];
    word_t      l_val [`LU_N];

    matrix_loader matrix_loader_inst (
        .clk(clk), .rst_n(rst_n), .mat_in(mat_in),
        .in_valid(in_valid), .in_ready(in_ready), .done(done),
        .step_en(step_en), .start(start), .step_cnt(step_cnt),
        .a_row0(a_row0), .a_row1(a_row1), .a_row2(a_row2)
    );

    lu_pe_array lu_pe_array_inst (
        .clk(clk), .rst_n(rst_n), .step_en(step_en), .start(start),
        .a_row0(a_row0), .a_row1(a_row1), .a_row2(a_row2),
        .u_bot(u_bot), .l_val(l_val), .pe_zero_div(pe_zero_div)
    );

    result_collector result_collector_inst (
        .clk(clk), .rst_n(rst_n), .step_cnt(step_cnt), .step_en(step_en),
        .u_bot(u_bot), .l_val(l_val), .pe_zero_div(pe_zero_div),
        .l_out(l_out), .u_out(u_out), .singular(singular),
        .out_valid(out_valid), .out_ready(out_ready), .done(done)
    );

endmodule

// File: src/lu_pe_array.sv
`include "lu_cfg.svh"

module lu_pe_array (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          step_en,
    input  logic          start,
    input  lu_pkg::word_t a_row0,
    input  lu_pkg::word_t a_row1,
    input  lu_pkg::word_t a_row2,
    output lu_pkg::word_t u_bot [`LU_N],
    output lu_pkg::word_t l_val [`LU_N],
    output logic [2:0]    pe_zero_div
);
    import lu_pkg::*;

    // Off-diagonal cells indexed (2,1), (3,1), (3,2).
    word_t d_u [`LU_N];
    word_t o_a [`LU_N];
    word_t o_u [`LU_N];

    // Cell (i,j), zero based, first sees data on step 1 + i + 2j.

    // Row 1.
    diag_pe #(.FIRST_STEP(1)) diag_pe_u11 (
        .clk(clk), .rst_n(rst_n), .step_en(step_en), .start(start),
        .a_in(a_row0), .u_out(d_u[0])
    );

    // Row 2.
    offdiag_pe #(.FIRST_STEP(2)) offdiag_pe_u21 (
        .clk(clk), .rst_n(rst_n), .step_en(step_en), .start(start),
        .a_in(a_row1), .u_in(d_u[0]), .a_out(o_a[0]), .u_out(o_u[0]),
        .l(l_val[0]), .zero_div(pe_zero_div[0])
    );

    diag_pe #(.FIRST_STEP(4)) diag_pe_u22 (
        .clk(clk), .rst_n(rst_n), .step_en(step_en), .start(start),
        .a_in(o_a[0]), .u_out(d_u[1])
    );

    // Row 3.
    offdiag_pe #(.FIRST_STEP(3)) offdiag_pe_u31 (
        .clk(clk), .rst_n(rst_n), .step_en(step_en), .start(start),
        .a_in(a_row2), .u_in(o_u[0]), .a_out(o_a[1]), .u_out(o_u[1]),
        .l(l_val[1]), .zero_div(pe_zero_div[1])
    );

    offdiag_pe #(.FIRST_STEP(5)) offdiag_pe_u32 (
        .clk(clk), .rst_n(rst_n), .step_en(step_en), .start(start),
        .a_in(o_a[1]), .u_in(d_u[1]), .a_out(o_a[2]), .u_out(o_u[2]),
        .l(l_val[2]), .zero_div(pe_zero_div[2])
    );

    diag_pe #(.FIRST_STEP(7)) diag_pe_u33 (
        .clk(clk), .rst_n(rst_n), .step_en(step_en), .start(start),
        .a_in(o_a[2]), .u_out(d_u[2])
    );

    // Values leaving the bottom of each column.
    assign u_bot[0] = o_u[1];
    assign u_bot[1] = o_u[2];
    assign u_bot[2] = d_u[2];

endmodule

// File: src/lu_pkg.sv
`include "lu_cfg.svh"

package lu_pkg;

    // ########################################################################
    // Data types
    // ########################################################################

    // Signed Q8.8 value.
    typedef logic signed [`LU_DWIDTH-1:0] word_t;

    // ########################################################################
    // Constants
    // ########################################################################

    // 1.0 in Q8.8, the diagonal of L.
    localparam word_t unit_word = word_t'(1 << `LU_FRAC);

endpackage

// File: src/matrix_loader.sv
`include "lu_cfg.svh"

module matrix_loader (
    input  logic          clk,
    input  logic          rst_n,
    input  lu_pkg::word_t mat_in [`LU_N][`LU_N],
    input  logic          in_valid,
    output logic          in_ready,
    input  logic          done,
    output logic          step_en,
    output logic          start,
    output logic [3:0]    step_cnt,
    output lu_pkg::word_t a_row0,
    output lu_pkg::word_t a_row1,
    output lu_pkg::word_t a_row2
);
    import lu_pkg::*;

    localparam logic [3:0] LAST_STEP = 4'(`LU_STEPS - 1);

    word_t mat_q [`LU_N][`LU_N];
    word_t skew [`LU_N];
    logic  accept;

    assign accept = in_valid && in_ready;
    assign start  = step_en && (step_cnt == 4'd0);

    // Row r element c goes out on step r + c.
    always_comb begin
        for (int r = 0; r < `LU_N; r++) begin
            skew[r] = '0;
            for (int c = 0; c < `LU_N; c++) begin
                if (int'(step_cnt) == r + c) skew[r] = mat_q[r][c];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ready <= 1'b1;
            step_en  <= 1'b0;
            step_cnt <= '0;
        end else begin
            if (accept) begin
                in_ready <= 1'b0;
                step_en  <= 1'b1;
                step_cnt <= '0;
            end else if (step_en) begin
                if (step_cnt == LAST_STEP) step_en <= 1'b0;
                else step_cnt <= step_cnt + 4'd1;
            end
            // Re-armed by the output transfer.
            if (done) in_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mat_q  <= mat_in;
            a_row0 <= '0;
            a_row1 <= '0;
            a_row2 <= '0;
        end else if (step_en) begin
            a_row0 <= skew[0];
            a_row1 <= skew[1];
            a_row2 <= skew[2];
        end
    end

endmodule

// File: src/offdiag_pe.sv
`include "lu_cfg.svh"

module offdiag_pe #(
    // Step on which the first operand pair reaches this cell.
    parameter int FIRST_STEP = 2
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          step_en,
    input  logic          start,
    input  lu_pkg::word_t a_in,
    input  lu_pkg::word_t u_in,
    output lu_pkg::word_t a_out,
    output lu_pkg::word_t u_out,
    output lu_pkg::word_t l,
    output logic          zero_div
);
    import lu_pkg::*;

    localparam int W = `LU_DWIDTH;

    logic [3:0]            slot_q;
    logic [3:0]            slot;
    logic                  first;
    logic signed [2*W-1:0] a_ext;
    logic signed [2*W-1:0] num_w;
    logic signed [2*W-1:0] den_w;
    logic signed [2*W-1:0] quot_w;
    logic signed [2*W-1:0] prod_w;
    logic signed [2*W-1:0] diff_w;
    word_t                 l_q;
    word_t                 a_q;
    word_t                 u_q;

    assign slot  = start ? 4'd0 : slot_q;
    assign first = int'(slot) == FIRST_STEP;

    // ########################################################################
    // Q8.8 arithmetic
    // ########################################################################

    always_comb begin
        a_ext = {{W{a_in[W-1]}}, a_in};
        den_w = {{W{u_in[W-1]}}, u_in};
        num_w = a_ext <<< `LU_FRAC;
        // Truncates toward zero.
        if (u_in == '0) quot_w = '0;
        else quot_w = num_w / den_w;
        prod_w = l_q * u_in;
        diff_w = a_ext - (prod_w >>> `LU_FRAC);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q   <= '0;
            l_q      <= '0;
            zero_div <= 1'b0;
        end else if (step_en) begin
            slot_q <= slot + 4'd1;
            if (first) begin
                l_q      <= quot_w[W-1:0];
                zero_div <= (u_in == '0);
            end else if (start) begin
                l_q      <= '0;
                zero_div <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step_en) begin
            if (start) begin
                u_q <= '0;
                a_q <= '0;
            end else begin
                u_q <= u_in;
                a_q <= first ? '0 : diff_w[W-1:0];
            end
        end
    end

    assign a_out = a_q;
    assign u_out = u_q;
    assign l     = l_q;

endmodule

// File: src/result_collector.sv
`include "lu_cfg.svh"

module result_collector (
    input  logic          clk,
    input  logic          rst_n,
    input  logic [3:0]    step_cnt,
    input  logic          step_en,
    input  lu_pkg::word_t u_bot [`LU_N],
    input  lu_pkg::word_t l_val [`LU_N],
    input  logic [2:0]    pe_zero_div,
    output lu_pkg::word_t l_out [`LU_N][`LU_N],
    output lu_pkg::word_t u_out [`LU_N][`LU_N],
    output logic          singular,
    output logic          out_valid,
    input  logic          out_ready,
    output logic          done
);
    import lu_pkg::*;

    localparam logic [3:0] LAST_STEP = 4'(`LU_STEPS - 1);

    word_t u_q [`LU_N][`LU_N];
    word_t l_q [`LU_N][`LU_N];
    logic  last_step;
    logic  filled_q;

    assign last_step = step_en && (step_cnt == LAST_STEP);
    assign done      = out_valid && out_ready;

    // ########################################################################
    // Capture schedule
    // ########################################################################

    always_ff @(posedge clk) begin
        if (step_en) begin
            case (step_cnt)
                4'd4: u_q[0][0] <= u_bot[0];
                4'd5: u_q[0][1] <= u_bot[0];
                4'd6: begin
                    u_q[0][2] <= u_bot[0];
                    u_q[1][1] <= u_bot[1];
                end
                4'd7: u_q[1][2] <= u_bot[1];
                LAST_STEP: begin
                    u_q[2][2] <= u_bot[2];
                    l_q[1][0] <= l_val[0];
                    l_q[2][0] <= l_val[1];
                    l_q[2][1] <= l_val[2];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filled_q  <= 1'b0;
            out_valid <= 1'b0;
            singular  <= 1'b0;
        end else begin
            filled_q <= last_step;
            if (filled_q) out_valid <= 1'b1;
            else if (done) out_valid <= 1'b0;
            if (last_step) singular <= |pe_zero_div;
        end
    end

    // Unit lower L, upper U.
    always_comb begin
        for (int r = 0; r < `LU_N; r++) begin
            for (int c = 0; c < `LU_N; c++) begin
                u_out[r][c] = (c >= r) ? u_q[r][c] : '0;
                if (r == c) l_out[r][c] = unit_word;
                else if (c < r) l_out[r][c] = l_q[r][c];
                else l_out[r][c] = '0;
            end
        end
    end

endmodule

// File: verification/lu_props.sv
`include "lu_cfg.svh"

module lu_props (
    input logic          clk,
    input logic          rst_n,
    input logic          in_valid,
    input logic          in_ready,
    input logic          out_valid,
    input logic          out_ready,
    input lu_pkg::word_t u_out [`LU_N][`LU_N]
);

    logic [`LU_N*`LU_N*`LU_DWIDTH-1:0] u_flat;

    always_comb begin
        for (int r = 0; r < `LU_N; r++) begin
            for (int c = 0; c < `LU_N; c++) begin
                u_flat[(r*`LU_N+c)*`LU_DWIDTH +: `LU_DWIDTH] = u_out[r][c];
            end
        end
    end

    // Idle handshake state right after reset release.
    reset_state_a: assert property (@(posedge clk) $rose(rst_n) |-> (!out_valid && in_ready))
        else $error("after reset out_valid=%b in_ready=%b", out_valid, in_ready);

    // Result held until the consumer takes it.
    hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(u_flat)))
        else $error("out_valid dropped or u_out changed before the output transfer");

    no_accept_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !(in_valid && in_ready))
        else $error("matrix accepted while a result was pending");

endmodule

// File: verification/lu_tb.sv
`include "lu_cfg.svh"

module lu_tb;
    import lu_pkg::*;

    localparam int TIMEOUT = 200;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    logic  in_ready;
    logic  out_valid;
    logic  out_ready;
    logic  singular;
    word_t mat_in [`LU_N][`LU_N];
    word_t l_out [`LU_N][`LU_N];
    word_t u_out [`LU_N][`LU_N];

    word_t stim [`LU_N][`LU_N];
    word_t exp_l [`LU_N][`LU_N];
    word_t exp_u [`LU_N][`LU_N];
    logic  exp_sing;
    logic  aborted;
    int    errors;
    int    test_errors;
    int    checks;
    int    sent;
    int    accepts;
    int    transfers;

    lu_decomp_top lu_decomp_top_inst (
        .clk(clk), .rst_n(rst_n), .mat_in(mat_in),
        .in_valid(in_valid), .in_ready(in_ready),
        .l_out(l_out), .u_out(u_out), .singular(singular),
        .out_valid(out_valid), .out_ready(out_ready)
    );

    bind lu_decomp_top lu_props lu_props_inst (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .out_valid(out_valid), .out_ready(out_ready), .u_out(u_out)
    );

    always #50 clk = ~clk;

    // Handshake counters sample the values from before the edge.
    always @(posedge clk) begin
        if (rst_n && in_valid && in_ready) accepts++;
        if (rst_n && out_valid && out_ready) transfers++;
    end

    // ########################################################################
    // Reference model
    // ########################################################################

    // Q8.8 divide that truncates toward zero and gives zero for a zero divisor.
    function automatic word_t q_div(input word_t a, input word_t u);
        logic signed [31:0] num;
        logic signed [31:0] den;
        num = a;
        den = u;
        if (u == 0) return '0;
        num = num <<< `LU_FRAC;
        return word_t'(num / den);
    endfunction

    // a - (l * u) >>> 8
    function automatic word_t q_msub(input word_t a, input word_t l, input word_t u);
        logic signed [31:0] aw;
        logic signed [31:0] lw;
        logic signed [31:0] uw;
        aw = a;
        lw = l;
        uw = u;
        return word_t'(aw - ((lw * uw) >>> `LU_FRAC));
    endfunction

    // Doolittle elimination without pivoting.
    task automatic ref_lu();
        word_t w [`LU_N][`LU_N];
        w = stim;
        exp_sing = 1'b0;
        for (int r = 0; r < `LU_N; r++) begin
            for (int c = 0; c < `LU_N; c++) begin
                exp_l[r][c] = (r == c) ? word_t'(1 << `LU_FRAC) : '0;
            end
        end
        for (int k = 0; k < `LU_N; k++) begin
            for (int i = k + 1; i < `LU_N; i++) begin
                if (w[k][k] == 0) exp_sing = 1'b1;
                exp_l[i][k] = q_div(w[i][k], w[k][k]);
                for (int j = k + 1; j < `LU_N; j++) begin
                    w[i][j] = q_msub(w[i][j], exp_l[i][k], w[k][j]);
                end
            end
        end
        for (int r = 0; r < `LU_N; r++) begin
            for (int c = 0; c < `LU_N; c++) begin
                exp_u[r][c] = (c >= r) ? w[r][c] : '0;
            end
        end
    endtask

    // ########################################################################
    // Checks and run control
    // ########################################################################

    task automatic check_value(input string name, input int exp, input int got);
        checks++;
        assert (got == exp) else begin
            $display("FAILED time=%0t signal=%s expected=%0d got=%0d", $time, name, exp, got);
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        for (int r = 0; r < `LU_N; r++) begin
            for (int c = 0; c < `LU_N; c++) begin
                check_value($sformatf("l_out[%0d][%0d]", r, c), exp_l[r][c], l_out[r][c]);
                check_value($sformatf("u_out[%0d][%0d]", r, c), exp_u[r][c], u_out[r][c]);
            end
        end
        check_value("singular", int'(exp_sing), int'(singular));
    endtask

    task automatic finish_run();
        $display("summary: %0d checks, %0d errors, %0d sent, %0d accepted, %0d returned",
                 checks, errors, sent, accepts, transfers);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("timeout: %s did not come within %0d cycles", what, TIMEOUT);
        test_errors++;
        aborted = 1'b1;
    endtask

    task automatic end_test(input string name, input int matrices);
        $display("%-13s %0d matrices, %0d errors", name, matrices, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #5;
    endtask

    // Sends one matrix through the DUT and holds out_ready off for ready_delay cycles.
    task automatic run_matrix(input int ready_delay);
        int n;
        if (aborted) return;
        ref_lu();
        mat_in = stim;
        in_valid = 1'b1;
        n = 0;
        while (!in_ready && n < TIMEOUT) begin
            step_cycle();
            n++;
        end
        if (!in_ready) begin
            timed_out("in_ready");
            return;
        end
        step_cycle();
        in_valid = 1'b0;
        sent++;
        n = 0;
        while (!out_valid && n < TIMEOUT) begin
            step_cycle();
            n++;
        end
        if (!out_valid) begin
            timed_out("out_valid");
            return;
        end
        check_value("out_valid latency", `LU_STEPS + 1, n);
        check_outputs();
        // Another matrix is offered while the result waits.
        in_valid = 1'b1;
        for (int d = 0; d < ready_delay; d++) begin
            step_cycle();
            check_value("out_valid", 1, int'(out_valid));
            check_value("in_ready", 0, int'(in_ready));
            check_outputs();
        end
        in_valid = 1'b0;
        out_ready = 1'b1;
        step_cycle();
        out_ready = 1'b0;
        check_value("out_valid", 0, int'(out_valid));
        check_value("in_ready", 1, int'(in_ready));
    endtask

    // Off-diagonal entries in [-4, 4] and diagonal entries in [8, 16].
    task automatic random_matrix();
        for (int r = 0; r < `LU_N; r++) begin
            for (int c = 0; c < `LU_N; c++) begin
                if (r == c) stim[r][c] = word_t'(2048 + int'($urandom_range(2048, 0)));
                else stim[r][c] = word_t'(int'($urandom_range(2048, 0)) - 1024);
            end
        end
    endtask

    // ########################################################################
    // Test sequence
    // ########################################################################

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        aborted = 1'b0;
        errors = 0;
        test_errors = 0;
        checks = 0;
        sent = 0;
        accepts = 0;
        transfers = 0;
        for (int r = 0; r < `LU_N; r++) begin
            for (int c = 0; c < `LU_N; c++) begin
                mat_in[r][c] = '0;
                stim[r][c] = (r == c) ? word_t'(256) : '0;
            end
        end
        void'($urandom(32'h93eb_5ec3));
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        step_cycle();

        run_matrix(0);
        end_test("identity", 1);

        // Diagonal 2.5, -3.0, 7.25.
        stim[0][0] = word_t'(640);
        stim[1][1] = word_t'(-768);
        stim[2][2] = word_t'(1856);
        run_matrix(2);
        end_test("diagonal", 1);

        repeat (200) begin
            random_matrix();
            run_matrix(0);
        end
        end_test("random", 200);

        // First pivot zero.
        for (int r = 0; r < `LU_N; r++) begin
            for (int c = 0; c < `LU_N; c++) begin
                stim[r][c] = word_t'((r * `LU_N + c) * 256);
            end
        end
        stim[2][2] = word_t'(9 * 256);
        run_matrix(1);
        check_value("singular", 1, int'(singular));
        check_value("l_out[1][0]", 0, l_out[1][0]);
        check_value("l_out[2][0]", 0, l_out[2][0]);
        end_test("zero_pivot", 1);

        repeat (30) begin
            random_matrix();
            run_matrix(int'($urandom_range(8, 0)));
        end
        check_value("accepted count", sent, accepts);
        check_value("returned count", sent, transfers);
        end_test("backpressure", 30);

        finish_run();
    end

endmodule
